// ==== filelist.f ====
+incdir+logic
logic/rv_isa_pkg.sv
logic/rv_pipe_pkg.sv
logic/fetch_unit.sv
logic/reg_file.sv
logic/insn_decoder.sv
logic/alu.sv
logic/pipe_control.sv
logic/rv_core.sv
verification/tb_rv_core.sv

// ==== logic/alu.sv ====
`timescale 1ns/1ps

module alu import rv_isa_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     i_squash,
  input  word_t    i_pc,
  input  reg_idx_t i_rs1,
  input  reg_idx_t i_rs2,
  input  word_t    i_rs1_data,
  input  word_t    i_rs2_data,
  input  word_t    i_imm,
  input  alu_op_e  i_alu_op,
  input  logic     i_a_is_pc,
  input  logic     i_b_is_imm,
  input  logic     i_wb_we,
  input  reg_idx_t i_wb_rd,
  input  word_t    i_wb_data,
  output word_t    o_result
);

  // execute stage registers
  alu_op_e  x_op;
  logic     x_a_is_pc;
  logic     x_b_is_imm;
  reg_idx_t x_rs1;
  reg_idx_t x_rs2;
  word_t    x_pc;
  word_t    x_rs1_data;
  word_t    x_rs2_data;
  word_t    x_imm;

  word_t src_a;
  word_t src_b;
  word_t op_a;
  word_t op_b;

  always_ff @(posedge clk) begin
    if (rst || i_squash) begin
      x_op       <= ALU_ADD;
      x_a_is_pc  <= 1'b0;
      x_b_is_imm <= 1'b0;
      x_rs1      <= '0;
      x_rs2      <= '0;
    end else begin
      x_op       <= i_alu_op;
      x_a_is_pc  <= i_a_is_pc;
      x_b_is_imm <= i_b_is_imm;
      x_rs1      <= i_rs1;
      x_rs2      <= i_rs2;
    end
  end

  always_ff @(posedge clk) begin
    if (i_squash) begin
      x_pc       <= '0;
      x_rs1_data <= '0;
      x_rs2_data <= '0;
      x_imm      <= '0;
    end else begin
      x_pc       <= i_pc;
      x_rs1_data <= i_rs1_data;
      x_rs2_data <= i_rs2_data;
      x_imm      <= i_imm;
    end
  end

  // forward from writeback, the producer one slot ahead
  assign src_a = (i_wb_we && i_wb_rd == x_rs1 && x_rs1 != '0) ? i_wb_data : x_rs1_data;
  assign src_b = (i_wb_we && i_wb_rd == x_rs2 && x_rs2 != '0) ? i_wb_data : x_rs2_data;

  assign op_a = x_a_is_pc ? x_pc : src_a;
  assign op_b = x_b_is_imm ? x_imm : src_b;

  always_comb begin
    case (x_op)
      ALU_ADD:    o_result = op_a + op_b;
      ALU_SUB:    o_result = op_a - op_b;
      ALU_SLL:    o_result = op_a << op_b[4:0];
      ALU_SLT:    o_result = word_t'($signed(op_a) < $signed(op_b));
      ALU_SLTU:   o_result = word_t'(op_a < op_b);
      ALU_XOR:    o_result = op_a ^ op_b;
      ALU_SRL:    o_result = op_a >> op_b[4:0];
      ALU_SRA:    o_result = word_t'($signed(op_a) >>> op_b[4:0]);
      ALU_OR:     o_result = op_a | op_b;
      ALU_AND:    o_result = op_a & op_b;
      // lui result is the shifted immediate
      ALU_PASS_B: o_result = op_b;
      default:    o_result = '0;
    endcase
  end

endmodule

// ==== logic/fetch_unit.sv ====
`timescale 1ns/1ps

`include "rv_settings.svh"

module fetch_unit import rv_isa_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  i_hold,
  output word_t o_pc
);

  word_t pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RV_RESET_PC;
    end else if (!i_hold) begin
      pc <= pc + `RV_PC_STEP;
    end
  end

  // straight-line fetch, no redirects in this subset
  assign o_pc = pc;

endmodule

// ==== logic/insn_decoder.sv ====
`timescale 1ns/1ps

module insn_decoder import rv_isa_pkg::*; (
  input  insn_t    i_insn,
  output reg_idx_t o_rs1,
  output reg_idx_t o_rs2,
  output word_t    o_imm,
  output alu_op_e  o_alu_op,
  output logic     o_a_is_pc,
  output logic     o_b_is_imm,
  output logic     o_is_ecall,
  output logic     o_illegal
);

  logic [6:0]  funct7;
  logic [2:0]  funct3;
  logic [19:0] upper;
  word_t       imm_i;
  word_t       imm_u;

  assign o_rs1  = i_insn.r_fmt.rs1;
  assign o_rs2  = i_insn.r_fmt.rs2;
  assign funct7 = i_insn.r_fmt.funct7;
  assign funct3 = i_insn.r_fmt.funct3;
  assign upper  = i_insn.i_u_fmt.upper;

  // I type keeps the top 12 bits, U type all 20
  assign imm_i = {{20{upper[19]}}, upper[19:8]};
  assign imm_u = {upper, 12'b0};

  always_comb begin
    o_imm      = imm_i;
    o_alu_op   = ALU_ADD;
    o_a_is_pc  = 1'b0;
    o_b_is_imm = 1'b0;
    o_is_ecall = 1'b0;
    o_illegal  = 1'b0;
    case (i_insn.r_fmt.opcode)
      OP_LUI: begin
        o_imm      = imm_u;
        o_alu_op   = ALU_PASS_B;
        o_b_is_imm = 1'b1;
      end
      OP_AUIPC: begin
        o_imm      = imm_u;
        o_a_is_pc  = 1'b1;
        o_b_is_imm = 1'b1;
      end
      OP_REG_IMM: begin
        o_b_is_imm = 1'b1;
        case (funct3)
          3'b000: o_alu_op = ALU_ADD;
          3'b010: o_alu_op = ALU_SLT;
          3'b011: o_alu_op = ALU_SLTU;
          3'b100: o_alu_op = ALU_XOR;
          3'b110: o_alu_op = ALU_OR;
          3'b111: o_alu_op = ALU_AND;
          // shamt sits in imm[4:0], funct7 must be clean
          3'b001: begin
            o_alu_op  = ALU_SLL;
            o_illegal = (funct7 != 7'b000_0000);
          end
          default: begin
            o_alu_op  = funct7[5] ? ALU_SRA : ALU_SRL;
            o_illegal = (funct7 != 7'b000_0000) && (funct7 != 7'b010_0000);
          end
        endcase
      end
      OP_REG_REG: begin
        case ({funct7, funct3})
          10'b000_0000_000: o_alu_op = ALU_ADD;
          10'b010_0000_000: o_alu_op = ALU_SUB;
          10'b000_0000_001: o_alu_op = ALU_SLL;
          10'b000_0000_010: o_alu_op = ALU_SLT;
          10'b000_0000_011: o_alu_op = ALU_SLTU;
          10'b000_0000_100: o_alu_op = ALU_XOR;
          10'b000_0000_101: o_alu_op = ALU_SRL;
          10'b010_0000_101: o_alu_op = ALU_SRA;
          10'b000_0000_110: o_alu_op = ALU_OR;
          10'b000_0000_111: o_alu_op = ALU_AND;
          default:          o_illegal = 1'b1;
        endcase
      end
      OP_SYSTEM: begin
        // ecall is the all-zero system word
        if (upper == '0 && i_insn.i_u_fmt.rd == '0) begin
          o_is_ecall = 1'b1;
        end else begin
          o_illegal = 1'b1;
        end
      end
      default: o_illegal = 1'b1;
    endcase
  end

endmodule

// ==== logic/pipe_control.sv ====
`timescale 1ns/1ps

module pipe_control import rv_pipe_pkg::*; (
  input  logic          clk,
  input  logic          rst,
  input  logic          i_is_ecall,
  input  logic          i_illegal,
  output logic          o_hold_fetch,
  output logic          o_squash,
  output cycle_status_e o_x_status,
  output cycle_status_e o_wb_status,
  output logic          o_wb_we,
  output logic          o_halt
);

  cycle_status_e d_status;
  cycle_status_e x_status;
  cycle_status_e wb_status;
  logic          x_ecall;
  logic          wb_ecall;
  logic          fetch_stopped;
  logic          halted;
  logic          d_ecall;

  // only a live ecall in decode stops the front end
  assign d_ecall = (d_status == CYCLE_VALID) && i_is_ecall;

  assign o_hold_fetch = d_ecall || fetch_stopped;

  // execute gets zero operands for anything that is not a real op
  assign o_squash = (d_status != CYCLE_VALID) || i_illegal;

  always_ff @(posedge clk) begin
    if (rst) begin
      d_status      <= CYCLE_RESET;
      x_status      <= CYCLE_RESET;
      wb_status     <= CYCLE_RESET;
      x_ecall       <= 1'b0;
      wb_ecall      <= 1'b0;
      fetch_stopped <= 1'b0;
      halted        <= 1'b0;
    end else begin
      // everything fetched behind an ecall is a bubble
      d_status <= (d_ecall || fetch_stopped) ? CYCLE_BUBBLE : CYCLE_VALID;
      if (d_status == CYCLE_VALID && i_illegal) begin
        x_status <= CYCLE_ILLEGAL;
      end else begin
        x_status <= d_status;
      end
      x_ecall   <= d_ecall;
      wb_status <= x_status;
      wb_ecall  <= x_ecall;
      if (d_ecall) begin
        fetch_stopped <= 1'b1;
      end
      if (wb_ecall) begin
        halted <= 1'b1;
      end
    end
  end

  assign o_x_status  = x_status;
  assign o_wb_status = wb_status;
  // every valid op except ecall writes rd
  assign o_wb_we     = (wb_status == CYCLE_VALID) && !wb_ecall;
  assign o_halt      = halted || wb_ecall;

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps

`include "rv_settings.svh"

module reg_file import rv_isa_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  reg_idx_t i_rs1,
  input  reg_idx_t i_rs2,
  output word_t    o_rs1_data,
  output word_t    o_rs2_data,
  input  logic     i_we,
  input  reg_idx_t i_rd,
  input  word_t    i_rd_data
);

  word_t regs [`RV_NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && i_rd != '0) begin
      regs[i_rd] <= i_rd_data;
    end
  end

  // write-through so decode sees the value retiring this cycle
  assign o_rs1_data = (i_we && i_rd == i_rs1 && i_rs1 != '0) ? i_rd_data : regs[i_rs1];
  assign o_rs2_data = (i_we && i_rd == i_rs2 && i_rs2 != '0) ? i_rd_data : regs[i_rs2];

endmodule

// ==== logic/rv_core.sv ====
`timescale 1ns/1ps

module rv_core import rv_isa_pkg::*, rv_pipe_pkg::*; (
  input  logic          clk,
  input  logic          rst,
  input  insn_t         i_insn,
  output word_t         o_pc,
  output word_t         o_wb_pc,
  output insn_t         o_wb_insn,
  output cycle_status_e o_wb_status,
  output logic          o_wb_we,
  output reg_idx_t      o_wb_rd,
  output word_t         o_wb_data,
  output logic          o_halt
);

  // decode stage
  word_t d_pc;
  insn_t d_insn;

  // pc and insn ride along with the execute stage
  word_t d_pc_x;
  insn_t d_insn_x;

  // writeback stage
  word_t wb_pc;
  insn_t wb_insn;
  word_t wb_result;

  logic          hold_fetch;
  logic          squash;
  cycle_status_e x_status;
  logic          wb_we;

  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t    rs1_data;
  word_t    rs2_data;
  word_t    imm;
  alu_op_e  alu_op;
  logic     a_is_pc;
  logic     b_is_imm;
  logic     is_ecall;
  logic     illegal;
  word_t    x_result;

  pipe_control u_pipe_control (
    .clk          (clk),
    .rst          (rst),
    .i_is_ecall   (is_ecall),
    .i_illegal    (illegal),
    .o_hold_fetch (hold_fetch),
    .o_squash     (squash),
    .o_x_status   (x_status),
    .o_wb_status  (o_wb_status),
    .o_wb_we      (wb_we),
    .o_halt       (o_halt)
  );

  fetch_unit u_fetch_unit (
    .clk    (clk),
    .rst    (rst),
    .i_hold (hold_fetch),
    .o_pc   (o_pc)
  );

  // instruction memory answers combinationally for o_pc
  always_ff @(posedge clk) begin
    if (rst) begin
      d_pc   <= '0;
      d_insn <= '0;
    end else begin
      d_pc   <= o_pc;
      d_insn <= i_insn;
    end
  end

  insn_decoder u_insn_decoder (
    .i_insn     (d_insn),
    .o_rs1      (rs1),
    .o_rs2      (rs2),
    .o_imm      (imm),
    .o_alu_op   (alu_op),
    .o_a_is_pc  (a_is_pc),
    .o_b_is_imm (b_is_imm),
    .o_is_ecall (is_ecall),
    .o_illegal  (illegal)
  );

  reg_file u_reg_file (
    .clk        (clk),
    .rst        (rst),
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data),
    .i_we       (wb_we),
    .i_rd       (o_wb_rd),
    .i_rd_data  (wb_result)
  );

  alu u_alu (
    .clk        (clk),
    .rst        (rst),
    .i_squash   (squash),
    .i_pc       (d_pc),
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .i_imm      (imm),
    .i_alu_op   (alu_op),
    .i_a_is_pc  (a_is_pc),
    .i_b_is_imm (b_is_imm),
    .i_wb_we    (wb_we),
    .i_wb_rd    (o_wb_rd),
    .i_wb_data  (wb_result),
    .o_result   (x_result)
  );

  always_ff @(posedge clk) begin
    d_pc_x   <= d_pc;
    d_insn_x <= d_insn;
  end

  // empty slots show up in the trace as all zeros
  always_ff @(posedge clk) begin
    if (x_status == CYCLE_VALID || x_status == CYCLE_ILLEGAL) begin
      wb_pc     <= d_pc_x;
      wb_insn   <= d_insn_x;
      wb_result <= x_result;
    end else begin
      wb_pc     <= '0;
      wb_insn   <= '0;
      wb_result <= '0;
    end
  end

  assign o_wb_pc   = wb_pc;
  assign o_wb_insn = wb_insn;
  assign o_wb_rd   = wb_insn.r_fmt.rd;
  assign o_wb_data = wb_result;
  assign o_wb_we   = wb_we;

endmodule

// ==== logic/rv_isa_pkg.sv ====
`include "rv_settings.svh"

package rv_isa_pkg;

  // one data or address word
  typedef logic [`RV_XLEN-1:0] word_t;

  // register number
  typedef logic [`RV_REG_IDX_W-1:0] reg_idx_t;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP_LUI     = 7'b01_101_11,
    OP_AUIPC   = 7'b00_101_11,
    OP_REG_IMM = 7'b00_100_11,
    OP_REG_REG = 7'b01_100_11,
    OP_SYSTEM  = 7'b11_100_11
  } opcode_e;

  // operation selected for the execute stage
  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_PASS_B = 4'd10
  } alu_op_e;

  // register fields and function codes
  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    opcode_e    opcode;
  } r_fmt_t;

  // upper 20 bits hold imm[11:0] for I type, imm[31:12] for U type
  typedef struct packed {
    logic [19:0] upper;
    reg_idx_t    rd;
    opcode_e     opcode;
  } i_u_fmt_t;

  // same instruction word, two decodings
  typedef union packed {
    r_fmt_t   r_fmt;
    i_u_fmt_t i_u_fmt;
  } insn_t;

endpackage

// ==== logic/rv_pipe_pkg.sv ====
package rv_pipe_pkg;

  // what a pipeline stage currently holds
  typedef enum logic [1:0] {
    // still the value loaded during reset
    CYCLE_RESET   = 2'd0,
    // a real instruction
    CYCLE_VALID   = 2'd1,
    // squashed slot behind an ecall
    CYCLE_BUBBLE  = 2'd2,
    // undecodable word, never written back
    CYCLE_ILLEGAL = 2'd3
  } cycle_status_e;

endpackage

// ==== logic/rv_settings.svh ====
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// data and address width of the RV32 core
`define RV_XLEN 32

// architectural integer registers
`define RV_NUM_REGS 32

// bits needed to name one register
`define RV_REG_IDX_W 5

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// sequential fetch increment in bytes
`define RV_PC_STEP 32'd4

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the rv_core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_rv_core -o sim_rv_core
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_rv_core)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Test OK"; then
  exit 0
fi
exit 1

// ==== verification/tb_rv_core.sv ====
`timescale 1ns/1ps

`include "rv_settings.svh"

module tb_rv_core import rv_isa_pkg::*, rv_pipe_pkg::*;;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 5;
  localparam int MAX_ROWS     = 96;
  localparam int DRAIN_CYCLES = 6;

  logic          clk;
  logic          rst;
  insn_t         i_insn;
  word_t         o_pc;
  word_t         o_wb_pc;
  insn_t         o_wb_insn;
  cycle_status_e o_wb_status;
  logic          o_wb_we;
  reg_idx_t      o_wb_rd;
  word_t         o_wb_data;
  logic          o_halt;

  // stimulus table with one row per fetch slot
  word_t         row_insn   [MAX_ROWS];
  reg_idx_t      row_rd     [MAX_ROWS];
  word_t         row_data   [MAX_ROWS];
  cycle_status_e row_status [MAX_ROWS];
  logic          row_we     [MAX_ROWS];
  int            n_rows = 0;
  int            ecall_row = -1;
  logic          table_ready = 1'b0;

  // architectural state of the reference model
  word_t       ref_regs [`RV_NUM_REGS];
  logic [31:0] lcg_state;
  int          n_checks = 0;
  int          n_errors = 0;

  rv_core DUT (
    .clk         (clk),
    .rst         (rst),
    .i_insn      (i_insn),
    .o_pc        (o_pc),
    .o_wb_pc     (o_wb_pc),
    .o_wb_insn   (o_wb_insn),
    .o_wb_status (o_wb_status),
    .o_wb_we     (o_wb_we),
    .o_wb_rd     (o_wb_rd),
    .o_wb_data   (o_wb_data),
    .o_halt      (o_halt)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] rand_word();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // x1..x16 from the top bits of the generator
  function automatic reg_idx_t rand_reg();
    logic [31:0] w;
    w = rand_word();
    return {1'b0, w[31:28]} + 5'd1;
  endfunction

  function automatic word_t row_pc(int idx);
    return `RV_RESET_PC + idx * `RV_PC_STEP;
  endfunction

  function automatic word_t alu_model(alu_op_e op, word_t a, word_t b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
      ALU_ADD:    return a + b;
      ALU_SUB:    return a + ~b + 32'd1;
      ALU_SLL:    return a << sh;
      // differing signs decide it alone
      ALU_SLT:    return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
      ALU_SLTU:   return {31'b0, a < b};
      ALU_XOR:    return a ^ b;
      ALU_SRL:    return a >> sh;
      ALU_SRA:    return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
      ALU_OR:     return a | b;
      ALU_AND:    return a & b;
      ALU_PASS_B: return b;
      default:    return '0;
    endcase
  endfunction

  function automatic logic [2:0] funct3_of(alu_op_e op);
    case (op)
      ALU_SLL:          return 3'b001;
      ALU_SLT:          return 3'b010;
      ALU_SLTU:         return 3'b011;
      ALU_XOR:          return 3'b100;
      ALU_SRL, ALU_SRA: return 3'b101;
      ALU_OR:           return 3'b110;
      ALU_AND:          return 3'b111;
      default:          return 3'b000;
    endcase
  endfunction

  function automatic logic [6:0] funct7_of(alu_op_e op);
    return (op == ALU_SUB || op == ALU_SRA) ? 7'b010_0000 : 7'b000_0000;
  endfunction

  task automatic add_row(word_t insn, reg_idx_t rd, word_t data, cycle_status_e status,
                         logic we);
    row_insn[n_rows]   = insn;
    row_rd[n_rows]     = rd;
    row_data[n_rows]   = data;
    row_status[n_rows] = status;
    row_we[n_rows]     = we;
    if (we && rd != '0) begin
      ref_regs[rd] = data;
    end
    n_rows++;
  endtask

  task automatic emit_imm(alu_op_e op, reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
    logic [11:0] field;
    word_t       insn;
    field = imm;
    // shift amounts keep only 5 bits and sra sets bit 30
    if (op == ALU_SRA) begin
      field = {7'b010_0000, imm[4:0]};
    end else if (op == ALU_SLL || op == ALU_SRL) begin
      field = {7'b000_0000, imm[4:0]};
    end
    insn = {field, rs1, funct3_of(op), rd, OP_REG_IMM};
    add_row(insn, rd, alu_model(op, ref_regs[rs1], {{20{field[11]}}, field}), CYCLE_VALID,
            1'b1);
  endtask

  task automatic emit_reg(alu_op_e op, reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
    word_t insn;
    insn = {funct7_of(op), rs2, rs1, funct3_of(op), rd, OP_REG_REG};
    add_row(insn, rd, alu_model(op, ref_regs[rs1], ref_regs[rs2]), CYCLE_VALID, 1'b1);
  endtask

  task automatic emit_imm_rand(alu_op_e op);
    reg_idx_t    rd;
    reg_idx_t    rs1;
    logic [31:0] w;
    rd  = rand_reg();
    rs1 = rand_reg();
    w   = rand_word();
    emit_imm(op, rd, rs1, w[31:20]);
  endtask

  task automatic emit_reg_rand(alu_op_e op);
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    rd  = rand_reg();
    rs1 = rand_reg();
    rs2 = rand_reg();
    emit_reg(op, rd, rs1, rs2);
  endtask

  task automatic emit_lui(reg_idx_t rd, logic [19:0] imm);
    add_row({imm, rd, OP_LUI}, rd, {imm, 12'b0}, CYCLE_VALID, 1'b1);
  endtask

  task automatic emit_auipc(reg_idx_t rd, logic [19:0] imm);
    add_row({imm, rd, OP_AUIPC}, rd, row_pc(n_rows) + {imm, 12'b0}, CYCLE_VALID, 1'b1);
  endtask

  task automatic emit_illegal(word_t insn);
    add_row(insn, insn[11:7], '0, CYCLE_ILLEGAL, 1'b0);
  endtask

  task automatic fill_table();
    logic [31:0] w;
    for (int r = 0; r < `RV_NUM_REGS; r++) begin
      ref_regs[r] = '0;
    end
    // load x1..x15 with each addi one slot behind its lui
    for (int r = 1; r < 16; r++) begin
      w = rand_word();
      emit_lui(reg_idx_t'(r), w[31:12]);
      emit_imm(ALU_ADD, reg_idx_t'(r), reg_idx_t'(r), w[11:0]);
    end
    emit_imm_rand(ALU_ADD);
    emit_imm_rand(ALU_SLT);
    emit_imm_rand(ALU_SLTU);
    emit_imm_rand(ALU_XOR);
    emit_imm_rand(ALU_OR);
    emit_imm_rand(ALU_AND);
    emit_imm_rand(ALU_SLL);
    emit_imm_rand(ALU_SRL);
    emit_imm_rand(ALU_SRA);
    w = rand_word();
    emit_auipc(5'd17, w[31:12]);
    emit_lui(5'd18, w[19:0]);
    emit_auipc(5'd19, w[19:0]);
    emit_reg_rand(ALU_ADD);
    emit_reg_rand(ALU_SUB);
    emit_reg_rand(ALU_SLL);
    emit_reg_rand(ALU_SLT);
    emit_reg_rand(ALU_SLTU);
    emit_reg_rand(ALU_XOR);
    emit_reg_rand(ALU_SRL);
    emit_reg_rand(ALU_SRA);
    emit_reg_rand(ALU_OR);
    emit_reg_rand(ALU_AND);
    // producer x20 with consumers at distance 1, 2 and 3
    emit_reg(ALU_ADD, 5'd20, 5'd1, 5'd2);
    emit_reg(ALU_SUB, 5'd21, 5'd20, 5'd3);
    emit_reg(ALU_XOR, 5'd22, 5'd20, 5'd21);
    emit_reg(ALU_SRA, 5'd23, 5'd20, 5'd22);
    emit_imm(ALU_SLT, 5'd24, 5'd21, 12'h800);
    // x0 must stay zero right behind a write to it
    emit_imm(ALU_ADD, 5'd0, 5'd5, 12'h123);
    emit_reg(ALU_OR, 5'd25, 5'd0, 5'd6);
    emit_reg(ALU_ADD, 5'd26, 5'd0, 5'd0);
    emit_reg(ALU_SLTU, 5'd27, 5'd0, 5'd7);
    w = rand_word();
    emit_illegal({w[31:7], 7'b111_1111});
    // mul is outside the subset so x3 keeps its value
    emit_illegal({7'b000_0001, 5'd1, 5'd2, 3'b000, 5'd3, OP_REG_REG});
    emit_reg(ALU_ADD, 5'd28, 5'd3, 5'd3);
    ecall_row = n_rows;
    add_row(32'h0000_0073, 5'd0, '0, CYCLE_VALID, 1'b0);
    // fetched behind the ecall and never retired
    emit_imm(ALU_ADD, 5'd9, 5'd9, 12'h001);
  endtask

  // fetch freezes on the slot right behind the ecall
  function automatic word_t fetch_pc(int c);
    return row_pc((c > ecall_row + 1) ? ecall_row + 1 : c);
  endfunction

  function automatic word_t insn_at(word_t pc);
    int idx;
    idx = int'((pc - `RV_RESET_PC) / `RV_PC_STEP);
    if (idx < n_rows) begin
      return row_insn[idx];
    end else begin
      // addi x0, x0, 0
      return 32'h0000_0013;
    end
  endfunction

  task automatic check_word(string name, word_t got, word_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Fail t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_idx(string name, reg_idx_t got, reg_idx_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Fail t=%0t %s got x%0d expected x%0d", $time, name, got, exp);
    end
  endtask

  task automatic check_status(string name, cycle_status_e got, cycle_status_e exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Fail t=%0t %s got %s expected %s", $time, name, got.name(), exp.name());
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Fail t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_idle();
    check_status("o_wb_status", o_wb_status, CYCLE_RESET);
    check_bit("o_wb_we", o_wb_we, 1'b0);
    check_bit("o_halt", o_halt, 1'b0);
  endtask

  // trace of cycle c belongs to the fetch three cycles earlier
  task automatic check_cycle(int c);
    int f;
    check_word("o_pc", o_pc, fetch_pc(c));
    if (c < 3) begin
      check_idle();
    end else begin
      f = c - 3;
      if (f <= ecall_row) begin
        check_status("o_wb_status", o_wb_status, row_status[f]);
        check_bit("o_wb_we", o_wb_we, row_we[f]);
        check_bit("o_halt", o_halt, f == ecall_row);
        check_word("o_wb_pc", o_wb_pc, row_pc(f));
        check_word("o_wb_insn", o_wb_insn, row_insn[f]);
        check_idx("o_wb_rd", o_wb_rd, row_rd[f]);
        if (row_we[f]) begin
          check_word("o_wb_data", o_wb_data, row_data[f]);
        end
      end else begin
        check_status("o_wb_status", o_wb_status, CYCLE_BUBBLE);
        check_bit("o_wb_we", o_wb_we, 1'b0);
        check_bit("o_halt", o_halt, 1'b1);
      end
    end
  endtask

  initial begin
    int n_cycles;
    rst       = 1'b1;
    i_insn    = '0;
    lcg_state = 32'd5091;
    fill_table();
    table_ready = 1'b1;
    n_cycles = ecall_row + 4 + DRAIN_CYCLES;
    // the last reset edge is the first edge of the loop below
    repeat (RESET_CYCLES - 1) begin
      @(posedge clk);
      @(negedge clk);
      check_word("o_pc", o_pc, `RV_RESET_PC);
      check_idle();
    end
    for (int c = 0; c < n_cycles; c++) begin
      @(posedge clk);
      rst    <= 1'b0;
      i_insn <= insn_at(fetch_pc(c));
      @(negedge clk);
      check_cycle(c);
    end
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    wait (table_ready);
    #((n_rows + 20) * CLK_PERIOD);
    $display("timeout: run still going after %0d cycles", n_rows + 20);
    $display("Test FAILED");
    $finish;
  end

endmodule
